/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // ==============================
  // address and line types
  // ==============================

  // byte address as seen by the fetch unit
  typedef logic [31:0] pc_t;

  // upper address bits naming one 16-byte line
  typedef logic [27:0] line_tag_t;

  // four 32-bit words, word 0 in the low bits
  typedef logic [127:0] line_t;

  // ==============================
  // cache read port
  // ==============================

  // request toward the cache, addr is line aligned
  typedef struct packed {
    logic valid;
    pc_t  addr;
  } rd_req_t;

  // response from the cache
  typedef struct packed {
    logic  valid;
    line_t data;
  } rd_rsp_t;

  // control FSM states
  typedef enum logic {
    IDLE,
    WAIT_RESP
  } fetch_state_e;

endpackage

`default_nettype wire

/* line_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
  parameter int LINE_W = 128
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              push_i,
  input  wire logic [LINE_W-1:0] push_line_i,
  input  wire logic              pop_i,
  input  wire logic              flush_i,
  output logic      [LINE_W-1:0] head_line_o,
  output logic                   full_o,
  output logic                   empty_o
);

  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);

  // line storage
  logic [LINE_W-1:0] mem [FIFO_DEPTH];

  // pointers carry one extra wrap bit
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;

  logic ptr_equal;
  logic do_push;
  logic do_pop;

  // ==============================
  // flags
  // ==============================

  assign ptr_equal = (rd_ptr == wr_ptr);
  assign full_o    = (rd_ptr == {~wr_ptr[PTR_W], wr_ptr[PTR_W-1:0]});

  // a line arriving into an empty FIFO already counts as present
  assign empty_o = ptr_equal & ~push_i;

  // flush wins over both push and pop
  assign do_push = push_i & ~full_o & ~flush_i;
  assign do_pop  = pop_i & ~empty_o & ~flush_i;

  // ==============================
  // pointers and storage
  // ==============================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rd_ptr <= '0;
    end else if (flush_i) begin
      // drop everything held
      rd_ptr <= wr_ptr;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[PTR_W-1:0]] <= push_line_i;
    end
  end

  // bypass the write when the FIFO holds nothing
  assign head_line_o = (ptr_equal && push_i) ? push_line_i : mem[rd_ptr[PTR_W-1:0]];

endmodule

`default_nettype wire

/* inst_select.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_select #(
  parameter int              LINE_W   = 128,
  parameter fetch_pkg::pc_t  RESET_PC = 32'h8000_0000
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire fetch_pkg::pc_t       pc_i,
  input  wire logic [LINE_W-1:0]    head_line_i,
  input  wire logic                 empty_i,
  input  wire logic                 flush_i,
  input  wire logic                 pop_i,
  output fetch_pkg::line_tag_t      head_tag_o,
  output logic                      pc_hit_o,
  output logic                      inst_valid_o,
  output fetch_pkg::pc_t            inst_o
);

  // line that sits at the FIFO head, or will once it arrives
  fetch_pkg::line_tag_t head_tag;

  logic [31:0] word_sel;

  // ==============================
  // head line tag
  // ==============================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      head_tag <= RESET_PC[31:4];
    end else if (flush_i) begin
      // jump target line becomes the new head
      head_tag <= pc_i[31:4];
    end else if (pop_i) begin
      head_tag <= head_tag + 1'b1;
    end
  end

  assign head_tag_o = head_tag;

  // ==============================
  // word select
  // ==============================

  assign pc_hit_o = (head_tag == pc_i[31:4]);

  // old contents are on their way out during a flush
  assign inst_valid_o = pc_hit_o & ~empty_i & ~flush_i;

  always_comb begin
    case (pc_i[3:2])
      2'd0:    word_sel = head_line_i[31:0];
      2'd1:    word_sel = head_line_i[63:32];
      2'd2:    word_sel = head_line_i[95:64];
      default: word_sel = head_line_i[127:96];
    endcase
  end

  // zero when nothing valid, easier to read in waves
  assign inst_o = inst_valid_o ? word_sel : '0;

endmodule

`default_nettype wire

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl #(
  parameter int              LINE_W   = 128,
  parameter fetch_pkg::pc_t  RESET_PC = 32'h8000_0000
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  jmp_flush_i,
  input  wire fetch_pkg::pc_t        pc_i,
  input  wire fetch_pkg::line_tag_t  head_tag_i,
  input  wire logic                  pc_hit_i,
  input  wire logic                  full_i,
  input  wire logic                  empty_i,
  output fetch_pkg::rd_req_t         ar_o,
  input  wire logic                  ar_ready_i,
  input  wire fetch_pkg::rd_rsp_t    r_i,
  output logic                       r_ready_o,
  output logic                       push_o,
  output logic [LINE_W-1:0]          push_line_o,
  output logic                       pop_o,
  output logic                       flush_o
);

  // lines held plus requested, never more than the FIFO holds
  localparam logic [2:0] MAX_LINES = 3'd4;

  fetch_pkg::fetch_state_e state;
  fetch_pkg::rd_req_t      ar_q;

  logic [2:0]           line_cnt;
  logic [2:0]           line_cnt_next;
  logic                 stale;
  logic                 req_take;
  logic                 rsp_take;
  logic                 issue;
  fetch_pkg::line_tag_t seq_tag;
  fetch_pkg::pc_t       req_addr;

  // ==============================
  // handshakes and FIFO control
  // ==============================

  assign req_take  = ar_q.valid & ar_ready_i;
  assign r_ready_o = (state == fetch_pkg::WAIT_RESP);
  assign rsp_take  = r_i.valid & r_ready_o;

  // responses to requests made before a jump are dropped
  assign push_o      = rsp_take & ~stale & ~jmp_flush_i;
  assign push_line_o = r_i.data;

  // pc has left the head line
  assign pop_o   = ~empty_i & ~pc_hit_i & ~jmp_flush_i;
  assign flush_o = jmp_flush_i;

  // ==============================
  // request address
  // ==============================

  assign seq_tag  = head_tag_i + fetch_pkg::line_tag_t'(line_cnt);
  assign req_addr = jmp_flush_i ? {pc_i[31:4], 4'b0000} : {seq_tag, 4'b0000};

  // a new request only when the previous one has been taken
  assign issue = (state == fetch_pkg::IDLE) & ~ar_q.valid &
                 (jmp_flush_i | ((line_cnt < MAX_LINES) & ~full_i));

  always_ff @(posedge clk) begin
    if (rst_n) begin
      ar_q <= '{valid: 1'b0, addr: {RESET_PC[31:4], 4'b0000}};
    end else if (req_take) begin
      ar_q.valid <= 1'b0;
    end else if (issue) begin
      ar_q <= '{valid: 1'b1, addr: req_addr};
    end
  end

  assign ar_o = ar_q;

  // ==============================
  // FSM
  // ==============================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= fetch_pkg::IDLE;
    end else begin
      case (state)
        fetch_pkg::IDLE: begin
          if (req_take) begin
            state <= fetch_pkg::WAIT_RESP;
          end
        end
        fetch_pkg::WAIT_RESP: begin
          if (rsp_take) begin
            state <= fetch_pkg::IDLE;
          end
        end
        default: state <= fetch_pkg::IDLE;
      endcase
    end
  end

  // request still pending or in flight when the jump came
  always_ff @(posedge clk) begin
    if (rst_n) begin
      stale <= 1'b0;
    end else if (jmp_flush_i &&
                 (ar_q.valid || (state == fetch_pkg::WAIT_RESP && !rsp_take))) begin
      stale <= 1'b1;
    end else if (rsp_take) begin
      stale <= 1'b0;
    end
  end

  // ==============================
  // outstanding line count
  // ==============================

  always_comb begin
    line_cnt_next = line_cnt;
    if (jmp_flush_i) begin
      line_cnt_next = issue ? 3'd1 : 3'd0;
    end else if (issue && !pop_o) begin
      line_cnt_next = line_cnt + 3'd1;
    end else if (pop_o && !issue) begin
      line_cnt_next = line_cnt - 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      line_cnt <= '0;
    end else begin
      line_cnt <= line_cnt_next;
    end
  end

endmodule

`default_nettype wire

/* fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer #(
  parameter int              LINE_W   = 128,
  parameter fetch_pkg::pc_t  RESET_PC = 32'h8000_0000
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // fetch side
  input  wire fetch_pkg::pc_t      pc_i,
  input  wire logic                jmp_flush_i,
  output logic                     inst_valid_o,
  output fetch_pkg::pc_t           inst_o,
  // cache read port
  output fetch_pkg::rd_req_t       ar_o,
  input  wire logic                ar_ready_i,
  input  wire fetch_pkg::rd_rsp_t  r_i,
  output logic                     r_ready_o
);

  logic                 push;
  logic [LINE_W-1:0]    push_line;
  logic                 pop;
  logic                 flush;
  logic [LINE_W-1:0]    head_line;
  logic                 full;
  logic                 empty;
  fetch_pkg::line_tag_t head_tag;
  logic                 pc_hit;

  // ==============================
  // control
  // ==============================

  fetch_ctrl #(
    .LINE_W   (LINE_W),
    .RESET_PC (RESET_PC)
  ) i_fetch_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .jmp_flush_i (jmp_flush_i),
    .pc_i        (pc_i),
    .head_tag_i  (head_tag),
    .pc_hit_i    (pc_hit),
    .full_i      (full),
    .empty_i     (empty),
    .ar_o        (ar_o),
    .ar_ready_i  (ar_ready_i),
    .r_i         (r_i),
    .r_ready_o   (r_ready_o),
    .push_o      (push),
    .push_line_o (push_line),
    .pop_o       (pop),
    .flush_o     (flush)
  );

  // ==============================
  // datapath
  // ==============================

  line_fifo #(
    .LINE_W (LINE_W)
  ) i_line_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .push_line_i (push_line),
    .pop_i       (pop),
    .flush_i     (flush),
    .head_line_o (head_line),
    .full_o      (full),
    .empty_o     (empty)
  );

  inst_select #(
    .LINE_W   (LINE_W),
    .RESET_PC (RESET_PC)
  ) i_inst_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc_i),
    .head_line_i  (head_line),
    .empty_i      (empty),
    .flush_i      (flush),
    .pop_i        (pop),
    .head_tag_o   (head_tag),
    .pc_hit_o     (pc_hit),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o)
  );

endmodule

`default_nettype wire

/* fetch_buffer_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_sva (
  input wire logic                    clk,
  input wire logic                    rst_n,
  input wire fetch_pkg::rd_req_t      ar_i,
  input wire logic                    ar_ready_i,
  input wire logic                    r_ready_i,
  input wire fetch_pkg::fetch_state_e state_i
);

  // a request not yet taken holds its address
  a_req_stable: assert property (@(posedge clk) disable iff (rst_n)
    (ar_i.valid && !ar_ready_i) |=> (ar_i.valid && $stable(ar_i.addr)))
    else $error("cache request changed before it was taken");

  // requests name whole lines
  a_req_aligned: assert property (@(posedge clk) disable iff (rst_n)
    ar_i.valid |-> (ar_i.addr[3:0] == 4'h0))
    else $error("cache request address is not line aligned");

  // IDLE without a taken request stays IDLE, so no response is awaited
  a_idle_no_ready: assert property (@(posedge clk) disable iff (rst_n)
    ((state_i == fetch_pkg::IDLE) && !(ar_i.valid && ar_ready_i)) |=> !r_ready_i)
    else $error("r_ready_o is high without a taken request");

  a_reset_quiet: assert property (@(posedge clk)
    rst_n |=> (!ar_i.valid && !r_ready_i))
    else $error("reset did not clear the cache handshake outputs");

endmodule

`default_nettype wire

/* fetch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_checker #(
  parameter fetch_pkg::pc_t RESET_PC = 32'h8000_0000
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire fetch_pkg::pc_t     pc_i,
  input  wire logic               jmp_flush_i,
  input  wire logic               inst_valid_i,
  input  wire fetch_pkg::pc_t     inst_i,
  input  wire fetch_pkg::rd_req_t ar_i,
  input  wire logic               ar_ready_i,
  input  wire logic               r_ready_i,
  output int                      err_count_o
);

  int             err_count     = 0;
  fetch_pkg::pc_t exp_addr      = 32'h0;
  fetch_pkg::pc_t stale_addr    = 32'h0;
  logic           stale_pending = 1'b0;
  logic           reset_seen    = 1'b0;
  logic           in_reset_q    = 1'b0;

  assign err_count_o = err_count;

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    err_count++;
  endtask

  // ==============================
  // reset outputs
  // ==============================

  task automatic check_quiet();
    if (inst_valid_i !== 1'b0) begin
      report_value("inst_valid_o", 32'(inst_valid_i), 32'h0);
    end
    if (ar_i.valid !== 1'b0) begin
      report_value("ar_o.valid", 32'(ar_i.valid), 32'h0);
    end
    if (r_ready_i !== 1'b0) begin
      report_value("r_ready_o", 32'(r_ready_i), 32'h0);
    end
  endtask

  // ==============================
  // words and requests
  // ==============================

  // memory rule, word address with low bits 01
  task automatic check_word();
    fetch_pkg::pc_t exp_word;
    exp_word = {pc_i[31:2], 2'b01};
    if (inst_valid_i === 1'b1 && inst_i !== exp_word) begin
      report_value("inst_o", inst_i, exp_word);
    end
  endtask

  task automatic check_request();
    int ahead;
    if (stale_pending) begin
      // request still pending from before a jump
      if (ar_i.addr !== stale_addr) begin
        report_value("ar_o.addr", ar_i.addr, stale_addr);
      end
      stale_pending = 1'b0;
    end else begin
      if (ar_i.addr !== exp_addr) begin
        report_value("ar_o.addr", ar_i.addr, exp_addr);
      end
      ahead = int'(ar_i.addr[31:4]) - int'(pc_i[31:4]);
      if (!jmp_flush_i && ahead > 3) begin
        $display("request for %h at %0t ns runs more than four lines ahead of pc %h",
                 ar_i.addr, $time, pc_i);
        err_count++;
      end
      exp_addr = exp_addr + 32'h10;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      // first edge only loads the reset values
      if (reset_seen) begin
        check_quiet();
      end
      reset_seen    = 1'b1;
      in_reset_q    = 1'b1;
      stale_pending = 1'b0;
      exp_addr      = {RESET_PC[31:4], 4'h0};
    end else begin
      if (in_reset_q) begin
        check_quiet();
      end
      in_reset_q = 1'b0;
      check_word();
      if (ar_i.valid && ar_ready_i) begin
        check_request();
      end
      if (jmp_flush_i) begin
        if (ar_i.valid && !ar_ready_i && !stale_pending) begin
          stale_pending = 1'b1;
          stale_addr    = exp_addr;
        end
        exp_addr = {pc_i[31:4], 4'h0};
      end
    end
  end

endmodule

`default_nettype wire

/* tb_fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_buffer;

  localparam fetch_pkg::pc_t RESET_PC     = 32'h8000_0000;
  localparam int             RESET_CYCLES = 5;
  localparam int             STEP_SLACK   = 20;

  logic               clk       = 1'b0;
  logic               rst_n     = 1'b1;
  fetch_pkg::pc_t     pc        = RESET_PC;
  logic               jmp_flush = 1'b0;
  logic               ar_ready  = 1'b0;
  fetch_pkg::rd_rsp_t rsp       = '0;
  logic               inst_valid;
  fetch_pkg::pc_t     inst;
  fetch_pkg::rd_req_t ar;
  logic               r_ready;
  int                 checker_errors;

  // trace steps and run limit
  fetch_pkg::pc_t step_pc[$];
  logic           step_flush[$];
  int             step_hold[$];
  int             tb_errors   = 0;
  int             cycle_cnt   = 0;
  int             cycle_limit = 0;

  // cache model state
  logic [31:0]    rng           = 32'd20437;
  fetch_pkg::pc_t pend_addr[$];
  logic           ar_taken      = 1'b0;
  fetch_pkg::pc_t ar_taken_addr = '0;
  logic           rsp_taken     = 1'b0;
  int             ready_wait    = -1;
  int             rsp_wait      = -1;

  fetch_buffer #(
    .LINE_W   (128),
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .jmp_flush_i  (jmp_flush),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .ar_o         (ar),
    .ar_ready_i   (ar_ready),
    .r_i          (rsp),
    .r_ready_o    (r_ready)
  );

  fetch_checker #(
    .RESET_PC (RESET_PC)
  ) i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .jmp_flush_i  (jmp_flush),
    .inst_valid_i (inst_valid),
    .inst_i       (inst),
    .ar_i         (ar),
    .ar_ready_i   (ar_ready),
    .r_ready_i    (r_ready),
    .err_count_o  (checker_errors)
  );

  bind fetch_ctrl fetch_buffer_sva i_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar_o),
    .ar_ready_i (ar_ready_i),
    .r_ready_i  (r_ready_o),
    .state_i    (state)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // line contents under the memory rule
  function automatic fetch_pkg::line_t mem_line(input fetch_pkg::pc_t addr);
    fetch_pkg::line_t line;
    fetch_pkg::pc_t   a;
    int               k;
    for (k = 0; k < 4; k++) begin
      a = addr + 32'(k * 4);
      line[32*k +: 32] = {a[31:2], 2'b01};
    end
    return line;
  endfunction

  // ==============================
  // trace and steps
  // ==============================

  task automatic read_trace();
    int             fd;
    int             fields;
    string          text;
    fetch_pkg::pc_t t_pc;
    int             t_flush;
    int             t_hold;
    fd = $fopen("fetch_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open fetch_trace.txt for reading");
      tb_errors++;
    end else begin
      while ($fgets(text, fd) > 0) begin
        if (text.getc(0) != "#") begin
          fields = $sscanf(text, "%h %d %d", t_pc, t_flush, t_hold);
          if (fields == 3) begin
            step_pc.push_back(t_pc);
            step_flush.push_back(t_flush != 0);
            step_hold.push_back(t_hold);
          end
        end
      end
      $fclose(fd);
      if (step_pc.size() == 0) begin
        $display("fetch_trace.txt holds no steps");
        tb_errors++;
      end
    end
    cycle_limit = RESET_CYCLES + 2;
    foreach (step_hold[i]) cycle_limit += step_hold[i] + STEP_SLACK;
  endtask

  // flush is a one cycle pulse, then wait for the word
  task automatic run_step(input fetch_pkg::pc_t addr, input logic flush, input int hold);
    pc        = addr;
    jmp_flush = flush;
    if (flush) begin
      @(negedge clk);
      jmp_flush = 1'b0;
    end
    do @(posedge clk); while (inst_valid !== 1'b1);
    @(negedge clk);
    repeat (hold) @(negedge clk);
  endtask

  task automatic report_summary();
    $display("errors: %0d from checker, %0d in testbench", checker_errors, tb_errors);
  endtask

  initial begin
    read_trace();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b0;
    foreach (step_pc[i]) run_step(step_pc[i], step_flush[i], step_hold[i]);
    repeat (2) @(negedge clk);
    report_summary();
    if (tb_errors + checker_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: trace not finished after %0d cycles", cycle_cnt);
      report_summary();
      $display("TEST FAILED");
      $finish;
    end
  end

  // ==============================
  // cache model
  // ==============================

  always @(posedge clk) begin
    ar_taken      = ar.valid & ar_ready;
    ar_taken_addr = ar.addr;
    rsp_taken     = rsp.valid & r_ready;
  end

  always @(negedge clk) begin
    if (rst_n) begin
      ar_ready   = 1'b0;
      rsp        = '0;
      ready_wait = -1;
      rsp_wait   = -1;
      pend_addr.delete();
    end else begin
      if (ar_taken) begin
        pend_addr.push_back(ar_taken_addr);
      end
      // ready for one cycle after 0 to 3 cycles
      if (ar_ready) begin
        ar_ready = 1'b0;
      end else if (ar.valid) begin
        if (ready_wait < 0) begin
          rng        = xorshift32(rng);
          ready_wait = int'(rng[1:0]);
        end
        if (ready_wait == 0) begin
          ar_ready = 1'b1;
        end
        ready_wait--;
      end
      if (rsp_taken) begin
        rsp.valid = 1'b0;
      end
      // response 1 to 4 cycles after the request
      if (!rsp.valid && pend_addr.size() > 0) begin
        if (rsp_wait < 0) begin
          rng      = xorshift32(rng);
          rsp_wait = int'(rng[1:0]) + 1;
        end
        rsp_wait--;
        if (rsp_wait == 0) begin
          rsp.data  = mem_line(pend_addr.pop_front());
          rsp.valid = 1'b1;
          rsp_wait  = -1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* fetch_trace.txt */
# fetch trace for tb_fetch_buffer, one step per line
# columns: pc (hex), jump flush (0 or 1), cycles to hold pc after its word is valid
80000000 0 2
80000004 0 0
80000008 0 1
8000000c 0 0
80000010 0 3
80000014 0 0
80000018 0 0
8000001c 0 1
80000020 0 0
80000024 0 2
80000028 0 0
8000002c 0 0
80000030 0 0
80000034 0 1
80001000 1 0
80001004 0 0
80001008 0 4
8000100c 0 0
80001010 0 1
80000040 1 1
80000044 0 0
80000048 0 0
8000004c 0 0
80000050 0 2
80000058 1 0
8000005c 0 0
80000060 0 1
80000064 0 0

/* fetch_buffer.f */
fetch_pkg.sv
line_fifo.sv
inst_select.sv
fetch_ctrl.sv
fetch_buffer.sv
fetch_buffer_sva.sv
fetch_checker.sv
tb_fetch_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module tb_fetch_buffer -f fetch_buffer.f \
  --Mdir obj_dir -o tb_fetch_buffer
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_fetch_buffer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "no pass message in $LOG"
  exit 1
fi
exit 0
